// ==== design/exu_macros.svh ====
// Data, tag and micro-op widths plus the CSR map of the reduced execution unit
// Only four CSR addresses exist and every other address counts as illegal

`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

//==================================================
// Datapath widths
//==================================================

`define EXU_DATA_WIDTH 32
`define EXU_TAG_WIDTH 4

// Both micro-op views are padded up to this width
`define EXU_UOP_WIDTH 6

//==================================================
// CSR addresses and exception codes
//==================================================

`define CSR_MSCRATCH 12'h340
// Bit 0 of this register enables the multiply
`define CSR_MEXTEN 12'h7C0
`define CSR_MINSTRET 12'hB02
// Read-only alias of the retired counter
`define CSR_INSTRET 12'hC02

`define INSTR_ILLEGAL 5'd2

`endif

// ==== design/exu_pkg.sv ====
// Micro-op types of the execution unit; both views of the union share one word
// Opcodes sit in the upper bits and the padding fills the bottom of each view
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

    //==================================================
    // Integer unit operations
    //==================================================

    // Branch compares come last so the ALU codes stay contiguous
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        MUL,
        BEQ,
        BNE,
        BLT,
        BLTU
    } itu_op_t;

    // The integer view carries only the opcode
    typedef struct packed {
        itu_op_t                   opcode;
        logic [`EXU_UOP_WIDTH-5:0] padding;
    } itu_uop_t;

    //==================================================
    // CSR unit operations
    //==================================================

    typedef enum logic [1:0] {
        CSR_SWAP,
        CSR_SET,
        CSR_CLEAR
    } csr_op_t;

    // Read and write flags let the issuer skip either side of the access
    typedef struct packed {
        csr_op_t                   opcode;
        logic                      read;
        logic                      write;
        logic [`EXU_UOP_WIDTH-5:0] padding;
    } csr_uop_t;

    // One micro-op word, decoded differently by each unit
    typedef union packed {
        itu_uop_t ITU;
        csr_uop_t CSR;
    } exu_uop_t;

endpackage : exu_pkg

`default_nettype wire

// ==== design/integer_unit.sv ====
// Single-cycle integer stage with one register of latency; MUL keeps the low half
// and returns zero while mul_enable_i is low; shifts use operand_b_i[4:0]
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module integer_unit import exu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       stall_i,
    input  logic                       valid_i,
    input  itu_uop_t                   operation_i,
    input  logic [`EXU_DATA_WIDTH-1:0] operand_a_i,
    input  logic [`EXU_DATA_WIDTH-1:0] operand_b_i,
    input  logic [`EXU_TAG_WIDTH-1:0]  tag_i,
    input  logic                       mul_enable_i,
    output logic [`EXU_DATA_WIDTH-1:0] result_o,
    output logic [`EXU_TAG_WIDTH-1:0]  tag_o,
    output logic                       valid_o,
    output logic                       taken_o
);

//==================================================
// Combinational ALU
//==================================================

    logic [4:0]                 shift_amount;
    logic [`EXU_DATA_WIDTH-1:0] product;
    logic                       is_equal, is_less_signed, is_less_unsigned;

    assign shift_amount = operand_b_i[4:0];

    // Only the low half of the product is kept
    assign product = operand_a_i * operand_b_i;

    // Comparisons are shared between the set-less-than and branch operations
    assign is_equal = operand_a_i == operand_b_i;
    assign is_less_signed = $signed(operand_a_i) < $signed(operand_b_i);
    assign is_less_unsigned = operand_a_i < operand_b_i;

    logic [`EXU_DATA_WIDTH-1:0] result_d;
    logic                       taken_d;

    always_comb begin : alu_logic
        // Branches and unused codes fall through with a zero result
        result_d = '0;
        taken_d = 1'b0;

        case (operation_i.opcode)
            ADD:  result_d = operand_a_i + operand_b_i;
            SUB:  result_d = operand_a_i - operand_b_i;
            AND:  result_d = operand_a_i & operand_b_i;
            OR:   result_d = operand_a_i | operand_b_i;
            XOR:  result_d = operand_a_i ^ operand_b_i;
            SLL:  result_d = operand_a_i << shift_amount;
            SRL:  result_d = operand_a_i >> shift_amount;
            SRA:  result_d = $unsigned($signed(operand_a_i) >>> shift_amount);
            SLT:  result_d = {{(`EXU_DATA_WIDTH-1){1'b0}}, is_less_signed};
            SLTU: result_d = {{(`EXU_DATA_WIDTH-1){1'b0}}, is_less_unsigned};

            // Disabled multiply still completes, just with a zero result
            MUL:  result_d = mul_enable_i ? product : '0;

            BEQ:  taken_d = is_equal;
            BNE:  taken_d = !is_equal;
            BLT:  taken_d = is_less_signed;
            BLTU: taken_d = is_less_unsigned;
            default: begin
                result_d = '0;
                taken_d = 1'b0;
            end
        endcase
    end : alu_logic

//==================================================
// Output register
//==================================================

    logic                       valid_q, taken_q;
    logic [`EXU_DATA_WIDTH-1:0] result_q;
    logic [`EXU_TAG_WIDTH-1:0]  tag_q;

    // Flush beats stall, so a flushed result never lingers on the port
    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_register
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end : valid_register

    // Payload only moves on an accepted operation and is masked by valid_q
    always_ff @(posedge clk_i) begin : payload_register
        if (valid_i && !stall_i) begin
            result_q <= result_d;
            taken_q <= taken_d;
            tag_q <= tag_i;
        end
    end : payload_register

    // Zero when idle so the top level can OR the two units together
    assign valid_o = valid_q;
    assign result_o = valid_q ? result_q : '0;
    assign tag_o = valid_q ? tag_q : '0;
    assign taken_o = valid_q & taken_q;

endmodule : integer_unit

`default_nettype wire

// ==== design/csr_unit.sv ====
// CSR stage with mscratch, the extension enable, minstret and its read-only alias
// A write lands on the edge that registers the result; the result is the old value
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module csr_unit import exu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       stall_i,
    input  logic                       valid_i,
    input  csr_uop_t                   operation_i,
    input  logic [`EXU_DATA_WIDTH-1:0] operand_a_i,
    input  logic [11:0]                address_i,
    input  logic [`EXU_TAG_WIDTH-1:0]  tag_i,
    input  logic                       instruction_retired_i,
    output logic [`EXU_DATA_WIDTH-1:0] result_o,
    output logic [`EXU_TAG_WIDTH-1:0]  tag_o,
    output logic                       valid_o,
    output logic                       exception_o,
    output logic                       mul_enable_o
);

//==================================================
// Address decode and read mux
//==================================================

    logic [`EXU_DATA_WIDTH-1:0] mscratch_q, mexten_q, minstret_q;
    logic                       sel_mscratch, sel_mexten, sel_minstret, sel_instret;
    logic [`EXU_DATA_WIDTH-1:0] old_value;

    always_comb begin : address_decode
        sel_mscratch = 1'b0;
        sel_mexten = 1'b0;
        sel_minstret = 1'b0;
        sel_instret = 1'b0;
        old_value = '0;

        case (address_i)
            `CSR_MSCRATCH: begin
                sel_mscratch = 1'b1;
                old_value = mscratch_q;
            end
            `CSR_MEXTEN: begin
                sel_mexten = 1'b1;
                old_value = mexten_q;
            end
            // Both counter addresses read the same register
            `CSR_MINSTRET: begin
                sel_minstret = 1'b1;
                old_value = minstret_q;
            end
            `CSR_INSTRET: begin
                sel_instret = 1'b1;
                old_value = minstret_q;
            end
            default: old_value = '0;
        endcase
    end : address_decode

    logic illegal_access;

    // Unknown address, or any write attempt on the read-only alias
    assign illegal_access = !(sel_mscratch | sel_mexten | sel_minstret | sel_instret)
                          | (sel_instret & operation_i.write);

//==================================================
// New value and register file
//==================================================

    logic [`EXU_DATA_WIDTH-1:0] new_value;

    always_comb begin : new_value_logic
        case (operation_i.opcode)
            CSR_SWAP:  new_value = operand_a_i;
            CSR_SET:   new_value = old_value | operand_a_i;
            CSR_CLEAR: new_value = old_value & ~operand_a_i;
            default:   new_value = old_value;
        endcase
    end : new_value_logic

    logic write_enable;

    // A flushed or illegal access never touches the registers
    assign write_enable = valid_i & operation_i.write & !illegal_access & !stall_i & !flush_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : csr_registers
        if (!rst_n_i) begin
            mscratch_q <= '0;
            mexten_q <= '0;
            minstret_q <= '0;
        end else begin
            if (write_enable && sel_mscratch) begin
                mscratch_q <= new_value;
            end
            if (write_enable && sel_mexten) begin
                mexten_q <= new_value;
            end
            // An explicit write takes priority over a retire in the same cycle
            if (write_enable && sel_minstret) begin
                minstret_q <= new_value;
            end else if (instruction_retired_i) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end : csr_registers

    assign mul_enable_o = mexten_q[0];

//==================================================
// Output register
//==================================================

    logic [`EXU_DATA_WIDTH-1:0] read_result;

    // Illegal accesses report the exception code instead of data
    always_comb begin : read_result_logic
        if (illegal_access) begin
            read_result = {{(`EXU_DATA_WIDTH-5){1'b0}}, `INSTR_ILLEGAL};
        end else begin
            read_result = operation_i.read ? old_value : '0;
        end
    end : read_result_logic

    logic                       valid_q, exception_q;
    logic [`EXU_DATA_WIDTH-1:0] result_q;
    logic [`EXU_TAG_WIDTH-1:0]  tag_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_register
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end : valid_register

    always_ff @(posedge clk_i) begin : payload_register
        if (valid_i && !stall_i) begin
            result_q <= read_result;
            exception_q <= illegal_access;
            tag_q <= tag_i;
        end
    end : payload_register

    assign valid_o = valid_q;
    assign result_o = valid_q ? result_q : '0;
    assign tag_o = valid_q ? tag_q : '0;
    assign exception_o = valid_q & exception_q;

endmodule : csr_unit

`default_nettype wire

// ==== design/execution_unit.sv ====
// Integer and CSR units behind one issue port; the issuer never raises both valids
// in one cycle, so their zero-gated outputs are simply ORed onto one result port
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module execution_unit import exu_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  logic                       stall_i,
    input  logic                       itu_valid_i,
    input  logic                       csr_valid_i,
    input  exu_uop_t                   operation_i,
    input  logic [`EXU_DATA_WIDTH-1:0] operand_a_i,
    input  logic [`EXU_DATA_WIDTH-1:0] operand_b_i,
    input  logic [`EXU_TAG_WIDTH-1:0]  tag_i,
    input  logic                       instruction_retired_i,
    output logic                       valid_o,
    output logic [`EXU_DATA_WIDTH-1:0] result_o,
    output logic [`EXU_TAG_WIDTH-1:0]  tag_o,
    output logic                       taken_o,
    output logic                       exception_o,
    output logic                       m_ext_o
);

//==================================================
// Integer unit
//==================================================

    logic [`EXU_DATA_WIDTH-1:0] itu_result;
    logic [`EXU_TAG_WIDTH-1:0]  itu_tag;
    logic                       itu_valid, mul_enable;

    integer_unit u_integer_unit (
        .clk_i        ( clk_i           ),
        .rst_n_i      ( rst_n_i         ),
        .flush_i      ( flush_i         ),
        .stall_i      ( stall_i         ),
        .valid_i      ( itu_valid_i     ),
        .operation_i  ( operation_i.ITU ),
        .operand_a_i  ( operand_a_i     ),
        .operand_b_i  ( operand_b_i     ),
        .tag_i        ( tag_i           ),
        .mul_enable_i ( mul_enable      ),
        .result_o     ( itu_result      ),
        .tag_o        ( itu_tag         ),
        .valid_o      ( itu_valid       ),
        .taken_o      ( taken_o         )
    );

//==================================================
// CSR unit
//==================================================

    logic [`EXU_DATA_WIDTH-1:0] csr_result;
    logic [`EXU_TAG_WIDTH-1:0]  csr_tag;
    logic                       csr_valid;

    // The CSR address rides in the low bits of the second operand
    csr_unit u_csr_unit (
        .clk_i                 ( clk_i                 ),
        .rst_n_i               ( rst_n_i               ),
        .flush_i               ( flush_i               ),
        .stall_i               ( stall_i               ),
        .valid_i               ( csr_valid_i           ),
        .operation_i           ( operation_i.CSR       ),
        .operand_a_i           ( operand_a_i           ),
        .address_i             ( operand_b_i[11:0]     ),
        .tag_i                 ( tag_i                 ),
        .instruction_retired_i ( instruction_retired_i ),
        .result_o              ( csr_result            ),
        .tag_o                 ( csr_tag               ),
        .valid_o               ( csr_valid             ),
        .exception_o           ( exception_o           ),
        .mul_enable_o          ( mul_enable            )
    );

    // Decoder side sees whether MUL is currently legal
    assign m_ext_o = mul_enable;

    // Each unit drives zeros when idle, so a plain OR merges the results
    assign valid_o = itu_valid | csr_valid;
    assign result_o = itu_result | csr_result;
    assign tag_o = itu_tag | csr_tag;

endmodule : execution_unit

`default_nettype wire

// ==== bench/exu_chk.sv ====
// Protocol assertions, bound to every execution_unit instance
// All rules except the reset check are off while rst_n_i is low
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module exu_chk (
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic                       stall_i,
    input logic                       itu_valid_i,
    input logic                       csr_valid_i,
    input logic                       valid_o,
    input logic [`EXU_DATA_WIDTH-1:0] result_o,
    input logic                       taken_o,
    input logic                       exception_o
);

//==================================================
// Issue side rules
//==================================================

    // The issuer picks one unit per cycle
    single_unit_issue: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) !(itu_valid_i && csr_valid_i)
    ) else $error("Integer and CSR valids were raised in the same cycle");

    // A stall holds the issue port quiet
    no_issue_in_stall: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) stall_i |-> !(itu_valid_i || csr_valid_i)
    ) else $error("An operation was issued during a stall");

//==================================================
// Result side rules
//==================================================

    // A taken branch is a valid integer result, and branches return zero
    taken_needs_valid: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
            taken_o |-> valid_o && result_o == '0 && !exception_o
    ) else $error("taken_o was high without a valid zero branch result");

    // The first edge after reset release still sees the reset values
    quiet_after_reset: assert property (
        @(posedge clk_i) $rose(rst_n_i) |-> !valid_o && !taken_o && !exception_o
    ) else $error("Outputs were not low right after reset release");

endmodule : exu_chk

bind execution_unit exu_chk i_exu_chk (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .stall_i     ( stall_i     ),
    .itu_valid_i ( itu_valid_i ),
    .csr_valid_i ( csr_valid_i ),
    .valid_o     ( valid_o     ),
    .result_o    ( result_o    ),
    .taken_o     ( taken_o     ),
    .exception_o ( exception_o )
);

`default_nettype wire

// ==== bench/exu_tb.sv ====
// Directed testbench for the execution unit; the tests share CSR state and run in order
// CSR expectations assume that only these tests retire instructions or write CSRs
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module exu_tb import exu_pkg::*; ();

//==================================================
// Parameters, signals and DUT
//==================================================

    localparam int CLK_PERIOD = 4;
    // Galois feedback mask for the taps 32, 30, 26 and 25
    localparam logic [31:0] LFSR_TAPS = 32'hA300_0000;
    // Reset, ALU, branch, multiply, mscratch, counter and stall/flush budgets in cycles
    localparam int TEST_CYCLES = 10 + 40 + 25 + 10 + 10 + 20 + 15;
    localparam int TIMEOUT_NS = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic                       clk, rst_n, flush, stall;
    logic                       itu_valid, csr_valid, instruction_retired;
    exu_uop_t                   operation;
    logic [`EXU_DATA_WIDTH-1:0] operand_a, operand_b, result;
    logic [`EXU_TAG_WIDTH-1:0]  tag, result_tag;
    logic                       valid, taken, exception, m_ext;

    // Stimulus state that lives across the tests
    logic [31:0]                lfsr_state;
    logic [`EXU_TAG_WIDTH-1:0]  tag_counter;
    logic [31:0]                mscratch_model;

    execution_unit i_execution_unit (
        .clk_i                 ( clk                 ),
        .rst_n_i               ( rst_n               ),
        .flush_i               ( flush               ),
        .stall_i               ( stall               ),
        .itu_valid_i           ( itu_valid           ),
        .csr_valid_i           ( csr_valid           ),
        .operation_i           ( operation           ),
        .operand_a_i           ( operand_a           ),
        .operand_b_i           ( operand_b           ),
        .tag_i                 ( tag                 ),
        .instruction_retired_i ( instruction_retired ),
        .valid_o               ( valid               ),
        .result_o              ( result              ),
        .tag_o                 ( result_tag          ),
        .taken_o               ( taken               ),
        .exception_o           ( exception           ),
        .m_ext_o               ( m_ext               )
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end : clock_gen

    // Ends a run that overshoots the summed test budget
    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end : watchdog

//==================================================
// Reference models and random source
//==================================================

    // Each returned bit costs one LFSR step
    function automatic logic [31:0] next_random(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return value;
    endfunction

    // Flipping the sign bits turns a signed compare into an unsigned one
    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic logic [31:0] alu_model(input itu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLL:  return a << sh;
            SRL:  return a >> sh;
            // Logical shift, then refill the vacated top bits with the sign
            SRA:  return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
            SLT:  return {31'h0, signed_less(a, b)};
            SLTU: return {31'h0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_model(input itu_op_t op, input logic [31:0] a,
                                          input logic [31:0] b);
        case (op)
            BEQ:  return a == b;
            BNE:  return a != b;
            BLT:  return signed_less(a, b);
            BLTU: return a < b;
            default: return 1'b0;
        endcase
    endfunction

//==================================================
// Drive and check helpers
//==================================================

    // Inputs change 1 ns after the edge, outputs are read at the same point
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_issue();
        itu_valid = 1'b0;
        csr_valid = 1'b0;
    endtask

    task automatic send_itu(input itu_op_t op, input logic [31:0] a, input logic [31:0] b);
        operation.ITU.opcode = op;
        operation.ITU.padding = '0;
        operand_a = a;
        operand_b = b;
        tag = tag_counter;
        tag_counter = tag_counter + 1'b1;
        itu_valid = 1'b1;
        csr_valid = 1'b0;
    endtask

    // The CSR address travels in the low 12 bits of operand_b
    task automatic send_csr(input csr_op_t op, input logic rd, input logic wr,
                            input logic [11:0] addr, input logic [31:0] src);
        operation.CSR.opcode = op;
        operation.CSR.read = rd;
        operation.CSR.write = wr;
        operation.CSR.padding = '0;
        operand_a = src;
        operand_b = {20'h0, addr};
        tag = tag_counter;
        tag_counter = tag_counter + 1'b1;
        csr_valid = 1'b1;
        itu_valid = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch on %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic expect_outputs(input logic exp_valid, input logic [31:0] exp_result,
                                  input logic [3:0] exp_tag, input logic exp_taken,
                                  input logic exp_exception);
        check_value("valid_o", valid, exp_valid);
        check_value("result_o", result, exp_result);
        check_value("tag_o", result_tag, exp_tag);
        check_value("taken_o", taken, exp_taken);
        check_value("exception_o", exception, exp_exception);
    endtask

    task automatic itu_roundtrip(input itu_op_t op, input logic [31:0] a, input logic [31:0] b,
                                 input logic [31:0] exp_result, input logic exp_taken);
        logic [3:0] sent_tag;
        send_itu(op, a, b);
        sent_tag = tag;
        step_cycle();
        clear_issue();
        expect_outputs(1'b1, exp_result, sent_tag, exp_taken, 1'b0);
    endtask

    task automatic csr_roundtrip(input csr_op_t op, input logic rd, input logic wr,
                                 input logic [11:0] addr, input logic [31:0] src,
                                 input logic [31:0] exp_result, input logic exp_exception);
        logic [3:0] sent_tag;
        send_csr(op, rd, wr, addr, src);
        sent_tag = tag;
        step_cycle();
        clear_issue();
        expect_outputs(1'b1, exp_result, sent_tag, 1'b0, exp_exception);
    endtask

    // A set with a zero source and no write is a plain read
    task automatic csr_read(input logic [11:0] addr, input logic [31:0] exp_value);
        csr_roundtrip(CSR_SET, 1'b1, 1'b0, addr, 32'h0, exp_value, 1'b0);
    endtask

//==================================================
// Directed tests
//==================================================

    task automatic alu_sweep();
        itu_op_t     alu_ops [10];
        logic [31:0] expected_results [$];
        logic [3:0]  expected_tags [$];
        logic [31:0] a, b, exp_result;
        logic [3:0]  exp_tag;
        int          total;
        alu_ops = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
        total = 30;
        for (int i = 0; i <= total; i++) begin
            // The previous result is checked while the next operation goes in
            if (i > 0) begin
                exp_result = expected_results.pop_front();
                exp_tag = expected_tags.pop_front();
                expect_outputs(1'b1, exp_result, exp_tag, 1'b0, 1'b0);
            end
            if (i < total) begin
                a = next_random(32);
                b = next_random(32);
                send_itu(alu_ops[i % 10], a, b);
                expected_results.push_back(alu_model(alu_ops[i % 10], a, b));
                expected_tags.push_back(tag);
            end else begin
                clear_issue();
            end
            step_cycle();
        end
    endtask

    task automatic branch_compares();
        itu_op_t     branch_ops [4];
        logic [31:0] pair_a [5];
        logic [31:0] pair_b [5];
        branch_ops = '{BEQ, BNE, BLT, BLTU};
        // Equal, plain lesser and greater, then pairs where the sign flips the order
        pair_a = '{32'h1234_5678, 32'd5, 32'd9, 32'hFFFF_FFFB, 32'd3};
        pair_b = '{32'h1234_5678, 32'd9, 32'd5, 32'd3, 32'hFFFF_FFFB};
        for (int p = 0; p < 5; p++) begin
            for (int k = 0; k < 4; k++) begin
                itu_roundtrip(branch_ops[k], pair_a[p], pair_b[p], 32'h0,
                              branch_model(branch_ops[k], pair_a[p], pair_b[p]));
            end
        end
    endtask

    task automatic mul_gating();
        logic [31:0] a, b;
        logic [63:0] full_product;
        a = next_random(32);
        b = next_random(32);
        check_value("m_ext_o", m_ext, 1'b0);
        itu_roundtrip(MUL, a, b, 32'h0, 1'b0);
        csr_roundtrip(CSR_SET, 1'b1, 1'b1, `CSR_MEXTEN, 32'h1, 32'h0, 1'b0);
        // The enable write has landed by the time its result is visible
        check_value("m_ext_o", m_ext, 1'b1);
        full_product = {32'h0, a} * {32'h0, b};
        itu_roundtrip(MUL, a, b, full_product[31:0], 1'b0);
    endtask

    task automatic mscratch_access();
        logic [31:0] value;
        value = next_random(32);
        csr_roundtrip(CSR_SWAP, 1'b1, 1'b1, `CSR_MSCRATCH, value, mscratch_model, 1'b0);
        mscratch_model = value;
        csr_read(`CSR_MSCRATCH, mscratch_model);
        value = next_random(32);
        csr_roundtrip(CSR_SET, 1'b1, 1'b1, `CSR_MSCRATCH, value, mscratch_model, 1'b0);
        mscratch_model = mscratch_model | value;
        csr_read(`CSR_MSCRATCH, mscratch_model);
        value = next_random(32);
        csr_roundtrip(CSR_CLEAR, 1'b1, 1'b1, `CSR_MSCRATCH, value, mscratch_model, 1'b0);
        mscratch_model = mscratch_model & ~value;
        csr_read(`CSR_MSCRATCH, mscratch_model);
    endtask

    task automatic retire_and_illegal();
        logic [31:0] retire_count;
        retire_count = 32'd1 + next_random(3);
        repeat (retire_count) begin
            instruction_retired = 1'b1;
            step_cycle();
        end
        instruction_retired = 1'b0;
        csr_read(`CSR_MINSTRET, retire_count);
        csr_read(`CSR_INSTRET, retire_count);
        // The alias refuses writes and the counter keeps its count
        csr_roundtrip(CSR_SWAP, 1'b1, 1'b1, `CSR_INSTRET, next_random(32),
                      32'(`INSTR_ILLEGAL), 1'b1);
        csr_read(`CSR_MINSTRET, retire_count);
        csr_roundtrip(CSR_SET, 1'b1, 1'b0, 12'h123, 32'h0, 32'(`INSTR_ILLEGAL), 1'b1);
    endtask

    task automatic stall_and_flush();
        logic [31:0] a, b, held_result;
        logic [3:0]  held_tag;
        a = next_random(32);
        b = next_random(32);
        held_result = alu_model(ADD, a, b);
        send_itu(ADD, a, b);
        held_tag = tag;
        step_cycle();
        clear_issue();
        expect_outputs(1'b1, held_result, held_tag, 1'b0, 1'b0);
        stall = 1'b1;
        repeat (3) begin
            step_cycle();
            expect_outputs(1'b1, held_result, held_tag, 1'b0, 1'b0);
        end
        stall = 1'b0;
        step_cycle();
        check_value("valid_o", valid, 1'b0);
        // An integer operation that meets a flush disappears
        send_itu(XOR, a, b);
        flush = 1'b1;
        step_cycle();
        clear_issue();
        flush = 1'b0;
        check_value("valid_o", valid, 1'b0);
        // So does a CSR write, and mscratch keeps its old value
        send_csr(CSR_SWAP, 1'b1, 1'b1, `CSR_MSCRATCH, ~mscratch_model);
        flush = 1'b1;
        step_cycle();
        clear_issue();
        flush = 1'b0;
        check_value("valid_o", valid, 1'b0);
        csr_read(`CSR_MSCRATCH, mscratch_model);
    endtask

//==================================================
// Test sequence
//==================================================

    initial begin : stimulus
        lfsr_state = 32'hfd87;
        tag_counter = '0;
        mscratch_model = '0;
        rst_n = 1'b0;
        flush = 1'b0;
        stall = 1'b0;
        itu_valid = 1'b0;
        csr_valid = 1'b0;
        instruction_retired = 1'b0;
        operation = '0;
        operand_a = '0;
        operand_b = '0;
        tag = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        step_cycle();
        expect_outputs(1'b0, 32'h0, 4'h0, 1'b0, 1'b0);
        alu_sweep();
        branch_compares();
        mul_gating();
        mscratch_access();
        retire_and_illegal();
        stall_and_flush();
        $display("Testbench passed");
        $finish;
    end : stimulus

endmodule : exu_tb

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/exu_pkg.sv
design/integer_unit.sv
design/csr_unit.sv
design/execution_unit.sv
bench/exu_chk.sv
bench/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the execution unit testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exu_tb -f sim.f --Mdir "$BUILD_DIR" -o exu_sim

"./$BUILD_DIR/exu_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Testbench passed" "$LOG"; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi
